//--- verilog/alu_ops_params.svh
// Sizing macros for the ALU overlay engine
// FIFO depth must be a power of two
// Programmable-full threshold must stay well below the depth, since
// upstream sees the almost-full flag a few cycles late
`ifndef ALU_OPS_PARAMS_SVH
`define ALU_OPS_PARAMS_SVH

// Packet fields
`define ALU_DATA_W 32
`define ALU_ADDR_W 16
`define ALU_ROUTE_W 8

// Descriptor packet count
`define ALU_COUNT_W 16

// Packet FIFOs
`define ALU_FIFO_DEPTH 16
`define ALU_PROG_THRESH 8

`endif

//--- verilog/alu_ops_pkg.sv
// Shared types and the ALU kernel for the overlay engine
// MAX and MIN compare the operands as unsigned values
// Results of ADD and SUB wrap at the data width
`default_nettype none

`include "alu_ops_params.svh"

package alu_ops_pkg;

    typedef enum logic [2:0] {
        OP_ADD  = 3'd0,
        OP_SUB  = 3'd1,
        OP_AND  = 3'd2,
        OP_OR   = 3'd3,
        OP_XOR  = 3'd4,
        OP_MAX  = 3'd5,
        OP_MIN  = 3'd6,
        OP_PASS = 3'd7
    } alu_opcode_t;

    typedef struct packed {
        logic [`ALU_ADDR_W-1:0]  address;
        logic [`ALU_ROUTE_W-1:0] route_from;
        logic [`ALU_ROUTE_W-1:0] route_to;
        logic [`ALU_DATA_W-1:0]  data;
    } mem_packet_t;

    typedef struct packed {
        alu_opcode_t             opcode;
        logic [`ALU_DATA_W-1:0]  operand;
        logic [`ALU_ROUTE_W-1:0] route_from;
        logic [`ALU_ROUTE_W-1:0] route_to;
    } alu_config_t;

    typedef enum logic [2:0] {
        IDLE        = 3'd0,
        CONFIG_REQ  = 3'd1,
        CONFIG_WAIT = 3'd2,
        BUSY        = 3'd3,
        PAUSE       = 3'd4,
        DRAIN       = 3'd5,
        DONE        = 3'd6
    } alu_ctrl_state_t;

    // Stateless kernel of the data against the configured operand
    function automatic logic [`ALU_DATA_W-1:0] alu_apply(
        input alu_opcode_t            op,
        input logic [`ALU_DATA_W-1:0] data,
        input logic [`ALU_DATA_W-1:0] operand
    );
        logic [`ALU_DATA_W-1:0] result;
        case (op)
            OP_ADD:  result = data + operand;
            OP_SUB:  result = data - operand;
            OP_AND:  result = data & operand;
            OP_OR:   result = data | operand;
            OP_XOR:  result = data ^ operand;
            OP_MAX:  result = (data > operand) ? data : operand;
            OP_MIN:  result = (data < operand) ? data : operand;
            default: result = data;
        endcase
        return result;
    endfunction

endpackage

`default_nettype wire

//--- verilog/packet_stream_if.sv
// Read side of a packet FIFO
// An item moves in a cycle with valid and pop both high
// pop has no effect while valid is low
`default_nettype none

interface packet_stream_if;
    import alu_ops_pkg::*;

    logic        valid;
    mem_packet_t payload;
    logic        pop;
    logic        empty;
    logic        prog_full;

    // FIFO side
    modport source (
        output valid,
        output payload,
        output empty,
        output prog_full,
        input  pop
    );

    // Consumer side
    modport sink (
        input  valid,
        input  payload,
        input  empty,
        input  prog_full,
        output pop
    );

endinterface

`default_nettype wire

//--- verilog/packet_fifo.sv
// Synchronous first-word-fall-through packet FIFO
// DEPTH must be a power of two
// A push into a full FIFO is dropped unless a pop happens in the same cycle
// prog_full is high while occupancy is at or above THRESH
`default_nettype none

`include "alu_ops_params.svh"

module packet_fifo #(
    parameter int DEPTH  = `ALU_FIFO_DEPTH,
    parameter int THRESH = `ALU_PROG_THRESH
) (
    input  logic                     ap_clk,
    input  logic                     areset_generator,
    input  logic                     push,
    input  alu_ops_pkg::mem_packet_t push_data,
    packet_stream_if.source          rd
);
    import alu_ops_pkg::*;

    localparam int PTR_W = $clog2(DEPTH);

    mem_packet_t      mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             full;
    logic             do_push;
    logic             do_pop;

    assign full    = (count == (PTR_W + 1)'(DEPTH));
    assign do_pop  = rd.valid & rd.pop;
    assign do_push = push & (~full | do_pop);

    // ------------------------------------------------------------------
    // Storage and pointers
    // ------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // ------------------------------------------------------------------
    // Read side status
    // ------------------------------------------------------------------
    // Head item shows as soon as it is written
    assign rd.payload   = mem[rd_ptr];
    assign rd.empty     = (count == '0);
    assign rd.valid     = (count != '0);
    assign rd.prog_full = (count >= (PTR_W + 1)'(THRESH));

endmodule

`default_nettype wire

//--- verilog/alu_ops_control.sv
// Job controller for the ALU overlay engine
// Inputs arrive already registered from the top level
// One configuration request per job, answered after any delay
// A job with a zero packet count finishes right after its configuration
// done is a one-cycle pulse with busy low in the same cycle
`default_nettype none

`include "alu_ops_params.svh"

module alu_ops_control (
    input  logic                     ap_clk,
    input  logic                     areset_generator,
    input  logic                     descriptor_valid,
    input  logic [`ALU_COUNT_W-1:0]  descriptor_count,
    input  logic                     config_valid,
    input  alu_ops_pkg::alu_config_t config_in,
    input  logic                     out_prog_full,
    input  logic                     result_taken,
    output logic                     config_req,
    output alu_ops_pkg::alu_config_t active_config,
    output logic                     accept_en,
    output logic                     busy,
    output logic                     done
);
    import alu_ops_pkg::*;

    alu_ctrl_state_t         state;
    alu_ctrl_state_t         next_state;
    logic [`ALU_COUNT_W-1:0] target_count;
    logic [`ALU_COUNT_W-1:0] taken_count;
    logic                    last_taken;

    // Final counted result leaves the output port this cycle
    assign last_taken = result_taken & ((taken_count + 1'b1) == target_count);

    // ------------------------------------------------------------------
    // State machine
    // ------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (descriptor_valid) begin
                    next_state = CONFIG_REQ;
                end
            end
            CONFIG_REQ: begin
                next_state = CONFIG_WAIT;
            end
            CONFIG_WAIT: begin
                if (config_valid) begin
                    next_state = (target_count == '0) ? DRAIN : BUSY;
                end
            end
            BUSY: begin
                if (last_taken) begin
                    next_state = DRAIN;
                end else if (out_prog_full) begin
                    next_state = PAUSE;
                end
            end
            PAUSE: begin
                if (last_taken) begin
                    next_state = DRAIN;
                end else if (~out_prog_full) begin
                    next_state = BUSY;
                end
            end
            DRAIN: begin
                next_state = DONE;
            end
            DONE: begin
                next_state = IDLE;
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

    // ------------------------------------------------------------------
    // Job count and configuration
    // ------------------------------------------------------------------
    // Count is only taken from a descriptor seen in IDLE
    always_ff @(posedge ap_clk) begin
        if (state == IDLE && descriptor_valid) begin
            target_count <= descriptor_count;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            taken_count   <= '0;
            active_config <= '0;
        end else begin
            case (state)
                CONFIG_WAIT: begin
                    taken_count <= '0;
                    if (config_valid) begin
                        active_config <= config_in;
                    end
                end
                BUSY, PAUSE: begin
                    if (result_taken) begin
                        taken_count <= taken_count + 1'b1;
                    end
                end
                // Drop the configuration of the finished job
                DRAIN: begin
                    active_config <= '0;
                end
                default: begin
                    taken_count <= taken_count;
                end
            endcase
        end
    end

    assign config_req = (state == CONFIG_REQ);
    assign accept_en  = (state == BUSY);
    assign busy       = (state != IDLE) && (state != DONE);
    assign done       = (state == DONE);

endmodule

`default_nettype wire

//--- verilog/alu_ops_datapath.sv
// Packet datapath of the ALU overlay engine
// Takes at most one packet every other cycle from the input FIFO
// Each result is pushed to the output FIFO the cycle after its pop
// Route fields come from the active configuration and the address passes through
`default_nettype none

module alu_ops_datapath (
    input  logic                     ap_clk,
    input  logic                     areset_generator,
    input  logic                     accept_en,
    input  alu_ops_pkg::alu_config_t active_config,
    packet_stream_if.sink            in_rd,
    output logic                     result_push,
    output alu_ops_pkg::mem_packet_t result_data
);
    import alu_ops_pkg::*;

    logic take;

    // ------------------------------------------------------------------
    // Input pop
    // ------------------------------------------------------------------
    // Hold off while a result sits in the register
    assign in_rd.pop = accept_en & ~in_rd.empty & ~result_push;
    assign take      = in_rd.valid & in_rd.pop;

    // ------------------------------------------------------------------
    // Result register
    // ------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            result_push <= 1'b0;
        end else begin
            result_push <= take;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (take) begin
            result_data.address    <= in_rd.payload.address;
            result_data.route_from <= active_config.route_from;
            result_data.route_to   <= active_config.route_to;
            result_data.data       <= alu_apply(active_config.opcode,
                                                in_rd.payload.data,
                                                active_config.operand);
        end
    end

endmodule

`default_nettype wire

//--- verilog/alu_ops_engine.sv
// Top level of the ALU overlay engine
// All inputs are registered once, except out_ready, which pops the
// output FIFO in the same cycle so that a result leaves when
// out_valid and out_ready are both high
// Upstream must stop pushing while in_almost_full is high
// Minimum latency from in_valid to out_valid is 4 cycles
`default_nettype none

`include "alu_ops_params.svh"

module alu_ops_engine (
    input  logic                    ap_clk,
    input  logic                    areset,
    input  logic                    descriptor_valid,
    input  logic [`ALU_COUNT_W-1:0] descriptor_count,
    output logic                    config_req,
    input  logic                    config_valid,
    input  logic [2:0]              config_opcode,
    input  logic [`ALU_DATA_W-1:0]  config_operand,
    input  logic [`ALU_ROUTE_W-1:0] config_route_from,
    input  logic [`ALU_ROUTE_W-1:0] config_route_to,
    input  logic                    in_valid,
    input  logic [`ALU_ADDR_W-1:0]  in_address,
    input  logic [`ALU_ROUTE_W-1:0] in_route_from,
    input  logic [`ALU_ROUTE_W-1:0] in_route_to,
    input  logic [`ALU_DATA_W-1:0]  in_data,
    output logic                    in_almost_full,
    output logic                    out_valid,
    output logic [`ALU_ADDR_W-1:0]  out_address,
    output logic [`ALU_ROUTE_W-1:0] out_route_from,
    output logic [`ALU_ROUTE_W-1:0] out_route_to,
    output logic [`ALU_DATA_W-1:0]  out_data,
    input  logic                    out_ready,
    output logic                    busy,
    output logic                    done
);
    import alu_ops_pkg::*;

    logic                    areset_generator;
    logic                    descriptor_valid_reg;
    logic [`ALU_COUNT_W-1:0] descriptor_count_reg;
    logic                    config_valid_reg;
    alu_config_t             config_reg;
    logic                    in_valid_reg;
    mem_packet_t             in_packet_reg;
    alu_config_t             active_config;
    logic                    accept_en;
    logic                    result_push;
    mem_packet_t             result_data;
    logic                    result_taken;

    packet_stream_if in_stream ();
    packet_stream_if out_stream ();

    // ------------------------------------------------------------------
    // Reset and input registers
    // ------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        areset_generator <= areset;
    end

    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            descriptor_valid_reg <= 1'b0;
            config_valid_reg     <= 1'b0;
            in_valid_reg         <= 1'b0;
        end else begin
            descriptor_valid_reg <= descriptor_valid;
            config_valid_reg     <= config_valid;
            in_valid_reg         <= in_valid;
        end
    end

    // Payloads packed into the package structs
    always_ff @(posedge ap_clk) begin
        descriptor_count_reg     <= descriptor_count;
        config_reg.opcode        <= alu_opcode_t'(config_opcode);
        config_reg.operand       <= config_operand;
        config_reg.route_from    <= config_route_from;
        config_reg.route_to      <= config_route_to;
        in_packet_reg.address    <= in_address;
        in_packet_reg.route_from <= in_route_from;
        in_packet_reg.route_to   <= in_route_to;
        in_packet_reg.data       <= in_data;
    end

    // Almost-full seen by upstream one cycle late
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            in_almost_full <= 1'b0;
        end else begin
            in_almost_full <= in_stream.prog_full;
        end
    end

    // ------------------------------------------------------------------
    // Input FIFO, datapath and controller
    // ------------------------------------------------------------------
    packet_fifo #(
        .DEPTH  (`ALU_FIFO_DEPTH),
        .THRESH (`ALU_PROG_THRESH)
    ) u_in_fifo (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .push             (in_valid_reg),
        .push_data        (in_packet_reg),
        .rd               (in_stream)
    );

    alu_ops_datapath u_datapath (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .accept_en        (accept_en),
        .active_config    (active_config),
        .in_rd            (in_stream),
        .result_push      (result_push),
        .result_data      (result_data)
    );

    alu_ops_control u_control (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .descriptor_valid (descriptor_valid_reg),
        .descriptor_count (descriptor_count_reg),
        .config_valid     (config_valid_reg),
        .config_in        (config_reg),
        .out_prog_full    (out_stream.prog_full),
        .result_taken     (result_taken),
        .config_req       (config_req),
        .active_config    (active_config),
        .accept_en        (accept_en),
        .busy             (busy),
        .done             (done)
    );

    // ------------------------------------------------------------------
    // Output FIFO and port unpacking
    // ------------------------------------------------------------------
    packet_fifo #(
        .DEPTH  (`ALU_FIFO_DEPTH),
        .THRESH (`ALU_PROG_THRESH)
    ) u_out_fifo (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .push             (result_push),
        .push_data        (result_data),
        .rd               (out_stream)
    );

    assign out_stream.pop = out_ready;
    assign result_taken   = out_stream.valid & out_ready;

    assign out_valid      = out_stream.valid;
    assign out_address    = out_stream.payload.address;
    assign out_route_from = out_stream.payload.route_from;
    assign out_route_to   = out_stream.payload.route_to;
    assign out_data       = out_stream.payload.data;

endmodule

`default_nettype wire

//--- verif/alu_ops_engine_tb.sv
// Testbench for the ALU overlay engine
// Jobs and packets come from verif/alu_ops_tests.txt with all fields in hex
// A job with more packets than the FIFO depth runs with out_ready held low
// until in_almost_full has been high for a while
// Packets are sent with inverted route fields so that replacement shows
`default_nettype none

`include "alu_ops_params.svh"

module alu_ops_engine_tb;
    timeunit 1ns;
    timeprecision 100ps;

    logic                    ap_clk;
    logic                    areset;
    logic                    descriptor_valid;
    logic [`ALU_COUNT_W-1:0] descriptor_count;
    logic                    config_req;
    logic                    config_valid;
    logic [2:0]              config_opcode;
    logic [`ALU_DATA_W-1:0]  config_operand;
    logic [`ALU_ROUTE_W-1:0] config_route_from;
    logic [`ALU_ROUTE_W-1:0] config_route_to;
    logic                    in_valid;
    logic [`ALU_ADDR_W-1:0]  in_address;
    logic [`ALU_ROUTE_W-1:0] in_route_from;
    logic [`ALU_ROUTE_W-1:0] in_route_to;
    logic [`ALU_DATA_W-1:0]  in_data;
    logic                    in_almost_full;
    logic                    out_valid;
    logic [`ALU_ADDR_W-1:0]  out_address;
    logic [`ALU_ROUTE_W-1:0] out_route_from;
    logic [`ALU_ROUTE_W-1:0] out_route_to;
    logic [`ALU_DATA_W-1:0]  out_data;
    logic                    out_ready;
    logic                    busy;
    logic                    done;

    // Test file contents
    logic [31:0] job_cnt[$];
    logic [31:0] job_op[$];
    logic [31:0] job_operand[$];
    logic [31:0] job_rf[$];
    logic [31:0] job_rt[$];
    int          job_first[$];
    logic [31:0] pkt_addr[$];
    logic [31:0] pkt_data[$];
    logic [31:0] pkt_exp[$];

    // Results still owed by the DUT in arrival order
    logic [31:0] exp_addr[$];
    logic [31:0] exp_rf[$];
    logic [31:0] exp_rt[$];
    logic [31:0] exp_data[$];

    integer seed;
    int     error_count;
    int     tests_run;
    int     tests_failed;
    int     req_pulses;
    int     done_pulses;
    int     results_in_job;
    int     cur_count;
    bit     timed_out;

    alu_ops_engine u_alu_ops_engine (
        .ap_clk            (ap_clk),
        .areset            (areset),
        .descriptor_valid  (descriptor_valid),
        .descriptor_count  (descriptor_count),
        .config_req        (config_req),
        .config_valid      (config_valid),
        .config_opcode     (config_opcode),
        .config_operand    (config_operand),
        .config_route_from (config_route_from),
        .config_route_to   (config_route_to),
        .in_valid          (in_valid),
        .in_address        (in_address),
        .in_route_from     (in_route_from),
        .in_route_to       (in_route_to),
        .in_data           (in_data),
        .in_almost_full    (in_almost_full),
        .out_valid         (out_valid),
        .out_address       (out_address),
        .out_route_from    (out_route_from),
        .out_route_to      (out_route_to),
        .out_data          (out_data),
        .out_ready         (out_ready),
        .busy              (busy),
        .done              (done)
    );

    always #10 ap_clk = ~ap_clk;

    // ------------------------------------------------------------------
    // Checks and run control
    // ------------------------------------------------------------------
    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] want);
        assert (got === want) else begin
            $display("** Error %s: got 0x%0h, expected 0x%0h", name, got, want);
            error_count++;
        end
    endtask

    task automatic check_condition(input bit ok, input string what);
        assert (ok) else begin
            $display("%0d ns: %s", $time, what);
            error_count++;
        end
    endtask

    task automatic finish_run();
        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed,
                 error_count);
        if (error_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    endtask

    task automatic report_timeout(input string what);
        $display("%0d ns: timed out waiting for %s", $time, what);
        error_count++;
        tests_failed++;
        timed_out = 1'b1;
    endtask

    task automatic load_tests();
        int          fd;
        int          code;
        int          total;
        string       line;
        logic [31:0] f1;
        logic [31:0] f2;
        logic [31:0] f3;
        logic [31:0] f4;
        logic [31:0] f5;
        total = 0;
        fd = $fopen("verif/alu_ops_tests.txt", "r");
        if (fd == 0) begin
            $display("cannot open the test file verif/alu_ops_tests.txt");
            error_count++;
        end else begin
            while (!$feof(fd)) begin
                code = $fgets(line, fd);
                if (code > 0 && line[0] == "J") begin
                    code = $sscanf(line.substr(1, line.len() - 1), "%h %h %h %h %h",
                                   f1, f2, f3, f4, f5);
                    check_condition(code == 5, "malformed job line in the test file");
                    job_first.push_back(pkt_addr.size());
                    job_cnt.push_back(f1);
                    job_op.push_back(f2);
                    job_operand.push_back(f3);
                    job_rf.push_back(f4);
                    job_rt.push_back(f5);
                    total += int'(f1);
                end else if (code > 0 && line[0] == "P") begin
                    code = $sscanf(line.substr(1, line.len() - 1), "%h %h %h",
                                   f1, f2, f3);
                    check_condition(code == 3, "malformed packet line in the test file");
                    pkt_addr.push_back(f1);
                    pkt_data.push_back(f2);
                    pkt_exp.push_back(f3);
                end
            end
            $fclose(fd);
            check_condition(total == pkt_addr.size(),
                            "job counts in the test file do not match its packet lines");
        end
    endtask

    // ------------------------------------------------------------------
    // Output consumer and pulse counting
    // ------------------------------------------------------------------
    always @(negedge ap_clk) begin
        if (config_req) begin
            req_pulses++;
            check_condition(busy == 1'b1, "busy low while config_req is high");
        end
        if (done) begin
            done_pulses++;
            check_condition(busy == 1'b0, "busy still high in the done cycle");
            check_condition(results_in_job == cur_count && exp_data.size() == 0,
                            "done came before all results were taken");
        end
        // Handshake completes at the next rising edge
        if (out_valid && out_ready) begin
            if (exp_data.size() == 0) begin
                check_condition(1'b0, "result presented with no packet outstanding");
            end else begin
                compare_value("out_address", 32'(out_address), exp_addr.pop_front());
                compare_value("out_route_from", 32'(out_route_from), exp_rf.pop_front());
                compare_value("out_route_to", 32'(out_route_to), exp_rt.pop_front());
                compare_value("out_data", 32'(out_data), exp_data.pop_front());
            end
            results_in_job++;
        end
    end

    // ------------------------------------------------------------------
    // One job from descriptor to done
    // ------------------------------------------------------------------
    task automatic run_job(input int j);
        int first;
        int cnt;
        int idx;
        int guard;
        int hold;
        int delay;
        int errors_before;
        bit stall;
        bit seen_full;
        bit released;
        first         = job_first[j];
        cnt           = int'(job_cnt[j]);
        stall         = (cnt > `ALU_FIFO_DEPTH);
        errors_before = error_count;
        seen_full     = 1'b0;
        released      = 1'b0;
        hold          = 0;

        @(posedge ap_clk);
        req_pulses       = 0;
        done_pulses      = 0;
        results_in_job   = 0;
        cur_count        = cnt;
        out_ready        <= ~stall;
        descriptor_valid <= 1'b1;
        descriptor_count <= job_cnt[j][`ALU_COUNT_W-1:0];
        @(posedge ap_clk);
        descriptor_valid <= 1'b0;

        guard = 0;
        while (req_pulses == 0) begin
            @(posedge ap_clk);
            guard++;
            if (guard > 40) begin
                report_timeout("config_req");
                return;
            end
        end
        delay = {$random(seed)} % 4;
        repeat (delay) @(posedge ap_clk);
        config_valid      <= 1'b1;
        config_opcode     <= job_op[j][2:0];
        config_operand    <= job_operand[j];
        config_route_from <= job_rf[j][`ALU_ROUTE_W-1:0];
        config_route_to   <= job_rt[j][`ALU_ROUTE_W-1:0];
        @(posedge ap_clk);
        config_valid <= 1'b0;

        idx   = 0;
        guard = 0;
        while (idx < cnt) begin
            @(posedge ap_clk);
            in_valid         <= 1'b0;
            descriptor_valid <= 1'b0;
            if (stall && !released && hold >= 30) begin
                out_ready <= 1'b1;
                released  = 1'b1;
            end
            if (in_almost_full) begin
                seen_full = 1'b1;
                hold++;
                guard++;
                if (guard > 400) begin
                    report_timeout("in_almost_full to fall");
                    return;
                end
            end else begin
                in_valid      <= 1'b1;
                in_address    <= pkt_addr[first + idx][`ALU_ADDR_W-1:0];
                in_route_from <= ~job_rf[j][`ALU_ROUTE_W-1:0];
                in_route_to   <= ~job_rt[j][`ALU_ROUTE_W-1:0];
                in_data       <= pkt_data[first + idx];
                exp_addr.push_back(pkt_addr[first + idx]);
                exp_rf.push_back(job_rf[j]);
                exp_rt.push_back(job_rt[j]);
                exp_data.push_back(pkt_exp[first + idx]);
                // Stray descriptor while busy must not start a new job
                if (idx == 0) begin
                    descriptor_valid <= 1'b1;
                    descriptor_count <= '1;
                end
                idx++;
                guard = 0;
            end
        end
        @(posedge ap_clk);
        in_valid         <= 1'b0;
        descriptor_valid <= 1'b0;
        if (stall) begin
            check_condition(seen_full, "in_almost_full never rose with out_ready held low");
            out_ready <= 1'b1;
        end

        guard = 0;
        while (done_pulses == 0) begin
            @(posedge ap_clk);
            guard++;
            if (guard > 1000) begin
                report_timeout("done");
                return;
            end
        end
        repeat (3) @(posedge ap_clk);
        check_condition(done_pulses == 1, "done pulsed more than once");
        check_condition(req_pulses == 1, "config_req did not pulse exactly once");
        check_condition(busy == 1'b0, "busy high after done");

        tests_run++;
        if (error_count == errors_before) begin
            $display("job %0d, opcode %0d, %0d packets: ok", j + 1, job_op[j], cnt);
        end else begin
            tests_failed++;
            $display("job %0d, opcode %0d, %0d packets: failed with %0d errors", j + 1,
                     job_op[j], cnt, error_count - errors_before);
        end
    endtask

    // ------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------
    initial begin
        int j;
        int errors_before;
        ap_clk            = 1'b0;
        areset            = 1'b1;
        descriptor_valid  = 1'b0;
        descriptor_count  = '0;
        config_valid      = 1'b0;
        config_opcode     = '0;
        config_operand    = '0;
        config_route_from = '0;
        config_route_to   = '0;
        in_valid          = 1'b0;
        in_address        = '0;
        in_route_from     = '0;
        in_route_to       = '0;
        in_data           = '0;
        out_ready         = 1'b0;
        seed              = 66;
        error_count       = 0;
        tests_run         = 0;
        tests_failed      = 0;
        req_pulses        = 0;
        done_pulses       = 0;
        results_in_job    = 0;
        cur_count         = 0;
        timed_out         = 1'b0;

        load_tests();

        repeat (2) @(posedge ap_clk);
        areset <= 1'b0;
        // Reset register inside the DUT adds a cycle
        repeat (2) @(posedge ap_clk);
        @(negedge ap_clk);
        errors_before = error_count;
        compare_value("out_valid", 32'(out_valid), 32'h0);
        compare_value("config_req", 32'(config_req), 32'h0);
        compare_value("busy", 32'(busy), 32'h0);
        compare_value("done", 32'(done), 32'h0);
        compare_value("in_almost_full", 32'(in_almost_full), 32'h0);
        tests_run++;
        if (error_count == errors_before) begin
            $display("reset values: ok");
        end else begin
            tests_failed++;
            $display("reset values: failed");
        end

        for (j = 0; j < job_cnt.size() && !timed_out; j++) begin
            run_job(j);
        end
        finish_run();
    end

endmodule

`default_nettype wire

//--- alu_ops_engine.f
+incdir+verilog
verilog/alu_ops_pkg.sv
verilog/packet_stream_if.sv
verilog/packet_fifo.sv
verilog/alu_ops_control.sv
verilog/alu_ops_datapath.sv
verilog/alu_ops_engine.sv
verif/alu_ops_engine_tb.sv

//--- run_sim.sh
#!/bin/sh
# Compiles the ALU overlay engine and its testbench with Verilator,
# runs the simulation and decides the result from the log.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
rm -f sim.log

verilator --binary --timing --assert \
    --timescale 1ns/100ps \
    --top-module alu_ops_engine_tb \
    -f alu_ops_engine.f \
    -o alu_ops_sim

./obj_dir/alu_ops_sim > sim.log 2>&1
cat sim.log

if grep -q "^TEST PASS$" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see sim.log"
    exit 1
fi

//--- verif/alu_ops_tests.txt
# J count opcode operand route_from route_to (hex, opcode 0 add 1 sub 2 and 3 or 4 xor 5 max 6 min 7 pass)
# P address data expected_data (hex, expected is data against operand truncated to 32 bits)
J 0002 7 DEADBEEF 01 02
P 0100 CAFEF00D CAFEF00D
P 0104 00000000 00000000
J 0002 1 00000003 33 44
P 0200 00000010 0000000D
P 0204 00000001 FFFFFFFE
J 0002 2 0F0F00FF 55 66
P 0300 12345678 02040078
P 0304 FFFFFFFF 0F0F00FF
J 0002 3 80000001 77 88
P 0400 00000000 80000001
P 0404 12345678 92345679
J 0002 4 A5A5A5A5 99 AA
P 0500 FFFFFFFF 5A5A5A5A
P 0504 A5A5A5A5 00000000
J 0002 5 00001000 BB CC
P 0600 00000FFF 00001000
P 0604 80000000 80000000
J 0002 6 00001000 DD EE
P 0700 00000FFF 00000FFF
P 0704 80000000 00001000
J 0014 0 00000100 5A A5
P 0800 00000000 00000100
P 0804 00000001 00000101
P 0808 000000FF 000001FF
P 080C 00000F00 00001000
P 0810 FFFFFF80 00000080
P 0814 FFFFFF00 00000000
P 0818 12345678 12345778
P 081C 7FFFFF00 80000000
P 0820 0000FEFF 0000FFFF
P 0824 11111111 11111211
P 0828 22222222 22222322
P 082C 33333333 33333433
P 0830 44444444 44444544
P 0834 55555555 55555655
P 0838 66666666 66666766
P 083C 77777777 77777877
P 0840 88888888 88888988
P 0844 99999999 99999A99
P 0848 ABCDEF00 ABCDF000
P 084C FFFFFFFF 000000FF
